//--- design/div_core.sv
// Non-restoring magnitude divider, one quotient bit per cycle
// Busy for INTEGER_WIDTH run cycles plus one correction cycle per request
// Divide by zero skips the run and returns the numerator as remainder
`timescale 1ns/1ps
`include "int_defines.svh"

module div_core (
    input  logic            clk,
    input  logic            rst,
    div_operand_if.sink     operand,
    div_magnitude_if.source magnitude
);
    import int_pkg::*;

    localparam int W = `INTEGER_WIDTH;
    localparam logic [`DIV_CNT_WIDTH-1:0] CNT_LAST = `DIV_CNT_WIDTH'(W - 1);

    div_state_e state;

    logic [`DIV_CNT_WIDTH-1:0] cnt;
    logic                      load;
    logic                      take;

    // Dividend shifts out MSB first, divisor stays put
    logic [W-1:0] divd;
    logic [W-1:0] divs;
    logic [W-1:0] quot;

    // Partial remainder with one extra sign bit
    logic [W:0] rem;
    logic [W:0] rem_shift;
    logic [W:0] rem_step;

    assign operand.ready = (state == DIV_IDLE);
    assign load          = operand.valid && operand.ready;
    assign take          = magnitude.valid && magnitude.ready;

    assign magnitude.mag_quot = quot;
    assign magnitude.mag_rem  = rem[W-1:0];

    // One non-restoring step
    always_comb begin
        rem_shift = {rem[W-1:0], divd[W-1]};
        if (rem[W]) begin
            rem_step = rem_shift + {1'b0, divs};
        end else begin
            rem_step = rem_shift - {1'b0, divs};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= DIV_IDLE;
            cnt             <= '0;
            magnitude.valid <= 1'b0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (load) begin
                        cnt   <= CNT_LAST;
                        state <= operand.div_zero ? DIV_DONE : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    if (cnt == '0) begin
                        state <= DIV_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DIV_DONE: begin
                    // First cycle corrects, then valid holds until taken
                    if (take) begin
                        magnitude.valid <= 1'b0;
                        state           <= DIV_IDLE;
                    end else begin
                        magnitude.valid <= 1'b1;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (load) begin
                    divd <= operand.abs_num;
                    divs <= operand.abs_den;
                    // Zero divisor keeps the numerator as remainder
                    rem  <= operand.div_zero ? {1'b0, operand.abs_num} : '0;
                    magnitude.op       <= operand.op;
                    magnitude.neg_quot <= operand.neg_quot;
                    magnitude.neg_rem  <= operand.neg_rem;
                    magnitude.div_zero <= operand.div_zero;
                end
            end
            DIV_RUN: begin
                divd <= divd << 1;
                rem  <= rem_step;
                quot <= {quot[W-2:0], ~rem_step[W]};
            end
            DIV_DONE: begin
                // Add the divisor back once if the remainder ended negative
                if (!magnitude.valid && rem[W]) begin
                    rem <= rem + {1'b0, divs};
                end
            end
            default: ;
        endcase
    end

endmodule

//--- design/div_if.sv
// Stage-to-stage links of the divider, valid/ready handshake
// Source holds its payload and valid until the transfer
`timescale 1ns/1ps
`include "int_defines.svh"

// Prepared operands, sign prep to core
interface div_operand_if;
    import int_pkg::*;

    logic                      valid;
    logic                      ready;
    div_op_e                   op;
    logic [`INTEGER_WIDTH-1:0] abs_num;
    logic [`INTEGER_WIDTH-1:0] abs_den;
    logic                      neg_quot;
    logic                      neg_rem;
    logic                      div_zero;

    modport source (
        output valid, op, abs_num, abs_den, neg_quot, neg_rem, div_zero,
        input  ready
    );

    modport sink (
        input  valid, op, abs_num, abs_den, neg_quot, neg_rem, div_zero,
        output ready
    );
endinterface

// Magnitude results, core to result stage
interface div_magnitude_if;
    import int_pkg::*;

    logic                      valid;
    logic                      ready;
    div_op_e                   op;
    logic [`INTEGER_WIDTH-1:0] mag_quot;
    logic [`INTEGER_WIDTH-1:0] mag_rem;
    logic                      neg_quot;
    logic                      neg_rem;
    logic                      div_zero;

    modport source (
        output valid, op, mag_quot, mag_rem, neg_quot, neg_rem, div_zero,
        input  ready
    );

    modport sink (
        input  valid, op, mag_quot, mag_rem, neg_quot, neg_rem, div_zero,
        output ready
    );
endinterface

//--- design/div_result_stage.sv
// Output slice: picks quotient or remainder and restores its sign
// Quotient of a divide by zero reads as 0
`timescale 1ns/1ps
`include "int_defines.svh"

module div_result_stage (
    input  logic          clk,
    input  logic          rst,
    input  logic          out_ready,
    output logic          out_valid,
    output int_pkg::int_t out_result,
    output logic          out_div_zero,
    div_magnitude_if.sink magnitude
);
    import int_pkg::*;

    localparam int W = `INTEGER_WIDTH;

    logic         take;
    logic [W-1:0] sel_mag;
    logic         sel_neg;

    assign magnitude.ready = !out_valid || out_ready;
    assign take            = magnitude.valid && magnitude.ready;

    always_comb begin
        if (magnitude.op == DIV_OP_REM) begin
            sel_mag = magnitude.mag_rem;
            sel_neg = magnitude.neg_rem;
        end else begin
            sel_mag = magnitude.div_zero ? '0 : magnitude.mag_quot;
            sel_neg = magnitude.neg_quot;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Negating 2**(W-1) wraps back to the most negative value
    always_ff @(posedge clk) begin
        if (take) begin
            if (sel_neg) begin
                out_result <= int_t'(~sel_mag + 1'b1);
            end else begin
                out_result <= int_t'(sel_mag);
            end
            out_div_zero <= magnitude.div_zero;
        end
    end

endmodule

//--- design/div_sign_prep.sv
// Input slice: splits each operand into sign and magnitude
// Magnitude of the most negative value is 2**(W-1), held unsigned
`timescale 1ns/1ps
`include "int_defines.svh"

module div_sign_prep (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  int_pkg::div_op_e  in_op,
    input  int_pkg::int_t     in_numerator,
    input  int_pkg::int_t     in_denominator,
    output logic              in_ready,
    div_operand_if.source     operand
);
    import int_pkg::*;

    localparam int W = `INTEGER_WIDTH;

    logic         take;
    logic         num_sign;
    logic         den_sign;
    logic [W-1:0] num_mag;
    logic [W-1:0] den_mag;

    // Free slot, or the held request leaves this cycle
    assign in_ready = !operand.valid || operand.ready;
    assign take     = in_valid && in_ready;

    assign num_sign = in_numerator[W-1];
    assign den_sign = in_denominator[W-1];

    // Two's-complement magnitudes
    always_comb begin
        num_mag = num_sign ? (~in_numerator + 1'b1) : in_numerator;
        den_mag = den_sign ? (~in_denominator + 1'b1) : in_denominator;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            operand.valid <= 1'b0;
        end else if (take) begin
            operand.valid <= 1'b1;
        end else if (operand.ready) begin
            operand.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            operand.op       <= in_op;
            operand.abs_num  <= num_mag;
            operand.abs_den  <= den_mag;
            operand.neg_quot <= num_sign ^ den_sign;
            // Remainder follows the numerator
            operand.neg_rem  <= num_sign;
            operand.div_zero <= (in_denominator == '0);
        end
    end

endmodule

//--- design/int_defines.svh
// Word and counter widths shared by the divider and its package
// DIV_CNT_WIDTH must be able to hold INTEGER_WIDTH-1
`ifndef INT_DEFINES_SVH
`define INT_DEFINES_SVH

// Data word width, 4 bits or more
`define INTEGER_WIDTH 16

// Core bit counter width
`define DIV_CNT_WIDTH 5

`endif

//--- design/int_divider.sv
// Signed divide unit, quotient or remainder per request, valid/ready on both sides
// Truncates toward zero, remainder takes the numerator sign
// Unloaded latency is INTEGER_WIDTH+3 cycles, 3 for a zero divisor
`timescale 1ns/1ps

module int_divider (
    input  logic             clk,
    input  logic             rst,

    // Request side
    input  logic             in_valid,
    input  int_pkg::div_op_e in_op,
    input  int_pkg::int_t    in_numerator,
    input  int_pkg::int_t    in_denominator,
    output logic             in_ready,

    // Result side
    input  logic             out_ready,
    output logic             out_valid,
    output int_pkg::int_t    out_result,
    output logic             out_div_zero
);

    // Links between the three slices
    div_operand_if   operand_bus ();
    div_magnitude_if magnitude_bus ();

    // Sign and magnitude split
    div_sign_prep i_sign_prep (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_numerator   (in_numerator),
        .in_denominator (in_denominator),
        .in_ready       (in_ready),
        .operand        (operand_bus.source)
    );

    // Iterative magnitude division
    div_core i_core (
        .clk       (clk),
        .rst       (rst),
        .operand   (operand_bus.sink),
        .magnitude (magnitude_bus.source)
    );

    // Result select and sign restore
    div_result_stage i_result_stage (
        .clk          (clk),
        .rst          (rst),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_div_zero (out_div_zero),
        .magnitude    (magnitude_bus.sink)
    );

endmodule

//--- design/int_pkg.sv
// Data type and enums for the signed divide unit
// int_t follows INTEGER_WIDTH from the defines header
`include "int_defines.svh"

package int_pkg;

    // Signed datapath word
    typedef logic signed [`INTEGER_WIDTH-1:0] int_t;

    // Request opcode
    typedef enum logic {
        DIV_OP_QUOT = 1'b0,
        DIV_OP_REM  = 1'b1
    } div_op_e;

    // Iterative core states
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

//--- sim/int_divider_tb.sv
// Random and corner testbench for int_divider, checked against a signed division model
// Stimulus comes from a 16-bit Fibonacci LFSR and is driven on the falling clock edge
`timescale 1ns/1ps
`include "int_defines.svh"

module int_divider_tb;
    import int_pkg::*;

    localparam int W            = `INTEGER_WIDTH;
    localparam int NUM_REQUESTS = 300 + 300 + 84 + 32 + 200;
    localparam int TIMEOUT      = NUM_REQUESTS * (W + 8) * 4;
    localparam int_t MIN_VAL    = {1'b1, {(W-1){1'b0}}};
    localparam int_t MAX_VAL    = ~MIN_VAL;

    logic    clk;
    logic    rst;
    logic    in_valid;
    div_op_e in_op;
    int_t    in_numerator;
    int_t    in_denominator;
    logic    in_ready;
    logic    out_ready;
    logic    out_valid;
    int_t    out_result;
    logic    out_div_zero;

    // Expected results in request order
    int_t  exp_result [$];
    logic  exp_zero [$];
    string exp_test [$];

    logic [15:0] lfsr_state;
    int          bp_mode;
    int          bp_left;
    bit          gaps_on;
    int          mismatch_count;
    int          other_count;
    int          cycle_count;
    int_t        corner_num [7];
    int_t        corner_den [6];

    int_divider i_dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_numerator   (in_numerator),
        .in_denominator (in_denominator),
        .in_ready       (in_ready),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_div_zero   (out_div_zero)
    );

    always #2 clk = ~clk;

    // Taps 16, 14, 13, 11; one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // Full-width value, shrunk half the time so small magnitudes show up too
    function automatic int_t random_operand();
        int_t val;
        val = int_t'(rand_bits(W));
        if (rand_bits(1)) begin
            val = val >>> rand_bits(4);
        end
        return val;
    endfunction

    // Truncating signed division, remainder follows the numerator
    function automatic int_t model_result(input div_op_e op, input int_t num, input int_t den);
        longint n;
        longint d;
        longint q;
        longint r;
        n = num;
        d = den;
        if (d == 0) begin
            q = 0;
            r = n;
        end else begin
            q = n / d;
            r = n - q * d;
        end
        return (op == DIV_OP_REM) ? int_t'(r) : int_t'(q);
    endfunction

    // Next falling edge, with out_ready updated for the back-pressure mode
    task automatic tick();
        @(negedge clk);
        if (bp_mode == 1) begin
            out_ready = (rand_bits(3) != 0);
        end else if (bp_mode == 2) begin
            if (bp_left == 0) begin
                out_ready = ~out_ready;
                bp_left   = out_ready ? rand_bits(3) + 1 : rand_bits(4) + 1;
            end else begin
                bp_left--;
            end
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // Entered and left on a falling edge
    task automatic send_request(input div_op_e op, input int_t num, input int_t den,
                                input string name);
        int gap;
        if (gaps_on) begin
            gap = rand_bits(2);
            repeat (gap) tick();
        end
        in_valid       = 1'b1;
        in_op          = op;
        in_numerator   = num;
        in_denominator = den;
        while (!in_ready) tick();
        @(posedge clk);
        exp_result.push_back(model_result(op, num, den));
        exp_zero.push_back(den == '0);
        exp_test.push_back(name);
        tick();
        in_valid = 1'b0;
    endtask

    task automatic check_output();
        int_t  exp_val;
        logic  exp_dz;
        string name;
        assert (exp_result.size() != 0) else begin
            other_count++;
            $display("ERROR: result %0d came out with no request waiting for it", out_result);
        end
        if (exp_result.size() != 0) begin
            exp_val = exp_result.pop_front();
            exp_dz  = exp_zero.pop_front();
            name    = exp_test.pop_front();
            assert (out_result === exp_val) else begin
                mismatch_count++;
                $display("MISMATCH %s result: expected %0d, actual %0d", name, exp_val, out_result);
            end
            assert (out_div_zero === exp_dz) else begin
                mismatch_count++;
                $display("MISMATCH %s div_zero: expected %0b, actual %0b",
                         name, exp_dz, out_div_zero);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            check_output();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("ERROR: timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int_t num;
        int_t den;
        clk            = 1'b0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_op          = DIV_OP_QUOT;
        in_numerator   = '0;
        in_denominator = '0;
        out_ready      = 1'b1;
        lfsr_state     = 16'd59591;
        bp_mode        = 1;
        bp_left        = 0;
        gaps_on        = 1'b1;
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        corner_num = '{int_t'(0), int_t'(1), int_t'(-1), int_t'(7), int_t'(-7), MIN_VAL, MAX_VAL};
        corner_den = '{int_t'(1), int_t'(-1), int_t'(3), int_t'(-3), MIN_VAL, MAX_VAL};

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 300; i++) begin
            num = random_operand();
            den = random_operand();
            if (den == '0) den = int_t'(1);
            send_request(DIV_OP_QUOT, num, den, "random_quotient");
        end

        for (int i = 0; i < 300; i++) begin
            num = random_operand();
            den = random_operand();
            if (den == '0) den = int_t'(-1);
            send_request(DIV_OP_REM, num, den, "random_remainder");
        end

        // Includes MIN_VAL / -1 and all four sign pairs of 7 and 3
        foreach (corner_num[i]) begin
            foreach (corner_den[j]) begin
                send_request(DIV_OP_QUOT, corner_num[i], corner_den[j], "corner_operands");
                send_request(DIV_OP_REM, corner_num[i], corner_den[j], "corner_operands");
            end
        end

        for (int i = 0; i < 32; i++) begin
            if (i < 2) num = (i == 0) ? int_t'(0) : MIN_VAL;
            else num = random_operand();
            send_request(i[0] ? DIV_OP_REM : DIV_OP_QUOT, num, '0, "divide_by_zero");
        end

        // Back to back requests against long stalls
        gaps_on = 1'b0;
        bp_mode = 2;
        for (int i = 0; i < 200; i++) begin
            num = random_operand();
            den = random_operand();
            if (rand_bits(4) == 0) den = '0;
            send_request(rand_bits(1) ? DIV_OP_REM : DIV_OP_QUOT, num, den, "back_pressure");
        end

        bp_mode = 0;
        for (int i = 0; i < (W + 8) * 4 && exp_result.size() != 0; i++) begin
            tick();
        end
        // A few more cycles to catch duplicated results
        repeat (W + 8) tick();
        assert (exp_result.size() == 0) else begin
            other_count++;
            $display("ERROR: %0d expected results never came out", exp_result.size());
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/int_pkg.sv
design/div_if.sv
design/div_sign_prep.sv
design/div_core.sv
design/div_result_stage.sv
design/int_divider.sv
sim/int_divider_tb.sv
